/* hdl/bus_pkg.sv */
package bus_pkg;

	// plain control port, one word per read or write strobe
	localparam int unsigned data_width = 32;

	typedef logic [data_width-1:0] word;

endpackage

/* hdl/smp_cmd_decode.sv */
`timescale 1ns/1ps

module smp_cmd_decode #(
	parameter int NUM_CORES = 4
) (
	input  logic         clk,
	input  logic         arst_n,
	input  logic         avl_write,
	input  bus_pkg::word avl_writedata,
	smp_cmd_if.src       cmd
);
	import smp_pkg::*;

	// cores that actually exist
	localparam logic [MAX_CORES-1:0] core_sel = MAX_CORES'((1 << NUM_CORES) - 1);

	smp_op op;
	logic  legal;

	assign op = smp_op'(avl_writedata[op_lsb +: op_width]);

	always_comb begin
		case (op)
			NOP, HALT, RESUME, STEP, CLR_BP, SET_MODE: legal = 1'b1;
			default: legal = 1'b0;  // reserved codes
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cmd.valid <= 1'b0;
		end else begin
			cmd.valid <= avl_write;  // no back-pressure, every write taken
		end
	end

	// payload only loads on a write
	always_ff @(posedge clk) begin
		if (avl_write) begin
			cmd.cmd.op    <= op;
			cmd.cmd.mask  <= avl_writedata[MAX_CORES-1:0] & core_sel;
			cmd.cmd.legal <= legal;
		end
	end

	// back-to-back valid needs back-to-back writes
	a_valid_pulse: assert property (
		@(posedge clk) disable iff (!arst_n)
		cmd.valid && $past(cmd.valid) |-> $past(avl_write) && $past(avl_write, 2)
	) else $error("smp_cmd_decode: valid held without a write");

endmodule

/* hdl/smp_cmd_if.sv */
`timescale 1ns/1ps

interface smp_cmd_if (
	input logic clk
);
	import smp_pkg::*;

	logic   valid;  // one cycle per accepted write
	smp_cmd cmd;

	modport src (
		input  clk,
		output valid,
		output cmd
	);

	modport run (
		input clk,
		input valid,
		input cmd
	);

	modport stat (
		input clk,
		input valid,
		input cmd
	);

endinterface

/* hdl/smp_ctrl.sv */
`timescale 1ns/1ps

module smp_ctrl #(
	parameter int NUM_CORES = 4  // 1 to 6
) (
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic                 avl_read,
	input  logic                 avl_write,
	input  bus_pkg::word         avl_writedata,
	output bus_pkg::word         avl_readdata,

	output logic [NUM_CORES-1:0] step,
	output logic [NUM_CORES-1:0] halt,
	input  logic [NUM_CORES-1:0] breakpoint,
	input  logic [NUM_CORES-1:0] cpu_alive,
	input  logic [NUM_CORES-1:0] cpu_halted
);

	logic [NUM_CORES-1:0] bp_flag;
	logic                 mode;

	smp_cmd_if cmd_bus (
		.clk(clk)
	);

	smp_cmd_decode #(.NUM_CORES(NUM_CORES)) decode
	(
		.cmd(cmd_bus),
		.*
	);

	smp_run_ctrl #(.NUM_CORES(NUM_CORES)) execute
	(
		.cmd(cmd_bus),
		.*
	);

	smp_status #(.NUM_CORES(NUM_CORES)) result
	(
		.cmd(cmd_bus),
		.*
	);

endmodule

/* hdl/smp_pkg.sv */
package smp_pkg;

	localparam int unsigned MAX_CORES = 8;  // width of the core mask field

	// opcode sits in the top nibble of the write word
	localparam int unsigned op_lsb   = 28;
	localparam int unsigned op_width = 4;

	typedef enum logic [op_width-1:0] {
		NOP      = 4'h0,
		HALT     = 4'h1,  // raise halt request on masked cores
		RESUME   = 4'h2,  // drop halt request and bp flag
		STEP     = 4'h3,  // single step, halted cores only
		CLR_BP   = 4'h4,  // clear bp flag, halt untouched
		SET_MODE = 4'h5   // mask bit 0 -> halt all on breakpoint
	} smp_op;

	typedef struct packed {
		smp_op                op;
		logic [MAX_CORES-1:0] mask;   // write bits 7:0
		logic                 legal;  // op is one of the above
	} smp_cmd;

	// status word layout
	localparam int unsigned alive_lsb  = 0;
	localparam int unsigned halted_lsb = 8;
	localparam int unsigned bp_lsb     = 16;
	localparam int unsigned hreq_lsb   = 24;
	localparam int unsigned hreq_width = 6;   // only cores 0 to 5 fit
	localparam int unsigned mode_bit   = 30;
	localparam int unsigned err_bit    = 31;

endpackage

/* hdl/smp_run_ctrl.sv */
`timescale 1ns/1ps

module smp_run_ctrl #(
	parameter int NUM_CORES = 4
) (
	input  logic                 clk,
	input  logic                 arst_n,
	smp_cmd_if.run               cmd,
	input  logic [NUM_CORES-1:0] breakpoint,
	input  logic [NUM_CORES-1:0] cpu_halted,
	output logic [NUM_CORES-1:0] halt,
	output logic [NUM_CORES-1:0] step,
	output logic [NUM_CORES-1:0] bp_flag,
	output logic                 mode
);
	import smp_pkg::*;

	logic [NUM_CORES-1:0] hreq_q, hreq_d;
	logic [NUM_CORES-1:0] bp_q, bp_d;
	logic [NUM_CORES-1:0] step_q, step_d;
	logic [NUM_CORES-1:0] cmd_mask;
	logic                 mode_q, mode_d;
	logic                 cmd_go;

	assign cmd_go   = cmd.valid && cmd.cmd.legal;
	assign cmd_mask = cmd.cmd.mask[NUM_CORES-1:0];

	always_comb begin
		hreq_d = hreq_q;
		bp_d   = bp_q;
		mode_d = mode_q;
		step_d = '0;

		if (cmd_go) begin
			case (cmd.cmd.op)
				HALT: hreq_d = hreq_q | cmd_mask;
				RESUME: begin
					hreq_d = hreq_q & ~cmd_mask;
					bp_d   = bp_q & ~cmd_mask;
				end
				// halted cores only, and never two pulses back to back
				STEP: step_d = cmd_mask & hreq_q & cpu_halted & ~step_q;
				CLR_BP: bp_d = bp_q & ~cmd_mask;
				SET_MODE: mode_d = cmd_mask[0];
				default: ;
			endcase
		end

		// applied last so a breakpoint beats a resume in the same cycle
		if (|breakpoint) begin
			bp_d   = bp_d | breakpoint;
			hreq_d = hreq_d | (mode_q ? {NUM_CORES{1'b1}} : breakpoint);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			hreq_q <= '0;
			bp_q   <= '0;
			step_q <= '0;
			mode_q <= 1'b0;
		end else begin
			hreq_q <= hreq_d;
			bp_q   <= bp_d;
			step_q <= step_d;
			mode_q <= mode_d;
		end
	end

	assign halt    = hreq_q;
	assign step    = step_q;
	assign bp_flag = bp_q;
	assign mode    = mode_q;

	// a core only steps while its halt request is held
	a_step_halted: assert property (
		@(posedge clk) disable iff (!arst_n)
		(step & ~halt) == '0
	) else $error("smp_run_ctrl: step without halt");

	a_step_single: assert property (
		@(posedge clk) disable iff (!arst_n)
		(step & $past(step)) == '0
	) else $error("smp_run_ctrl: step longer than one cycle");

endmodule

/* hdl/smp_status.sv */
`timescale 1ns/1ps

module smp_status #(
	parameter int NUM_CORES = 4
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 avl_read,
	output bus_pkg::word         avl_readdata,
	smp_cmd_if.stat              cmd,
	input  logic [NUM_CORES-1:0] cpu_alive,
	input  logic [NUM_CORES-1:0] cpu_halted,
	input  logic [NUM_CORES-1:0] halt,
	input  logic [NUM_CORES-1:0] bp_flag,
	input  logic                 mode
);
	import bus_pkg::*;
	import smp_pkg::*;

	logic                  err_q;
	logic                  err_set;
	logic [hreq_width-1:0] hreq_field;
	word                   status_word;

	assign err_set = cmd.valid && !cmd.cmd.legal;

	// cores above NUM_CORES read as zero
	always_comb begin
		hreq_field                  = '0;
		hreq_field[NUM_CORES-1:0]   = halt;

		status_word                 = '0;
		status_word[alive_lsb +: NUM_CORES]  = cpu_alive;
		status_word[halted_lsb +: NUM_CORES] = cpu_halted;
		status_word[bp_lsb +: NUM_CORES]     = bp_flag;
		status_word[hreq_lsb +: hreq_width]  = hreq_field;
		status_word[mode_bit]       = mode;
		status_word[err_bit]        = err_q;
	end

	// sticky until read; an error landing on the read edge survives it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			err_q <= 1'b0;
		end else begin
			err_q <= (err_q && !avl_read) || err_set;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			avl_readdata <= '0;
		end else if (avl_read) begin
			avl_readdata <= status_word;  // snapshot before this edge
		end
	end

	a_rdata_hold: assert property (
		@(posedge clk) disable iff (!arst_n)
		!avl_read |=> $stable(avl_readdata)
	) else $error("smp_status: readdata changed without a read");

endmodule

/* run_sim.sh */
#!/bin/sh
# build the smp_ctrl testbench with Verilator and run it
# the run passes only if the simulation prints the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module smp_ctrl_tb \
	-f smp_ctrl.f \
	-o smp_ctrl_sim \
	&& ./obj_dir/smp_ctrl_sim | tee /dev/stderr | grep -qx "=== PASS ===" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/smp_ctrl_tests.svh */
// each test starts and ends at a drive point, all cores released

task automatic test_reset_state();
	word got;
	$display("test 1: reset state");
	check_lines("halt after reset", halt, '0);
	check_lines("step after reset", step, '0);
	// this read edge is the one where the model first goes alive
	read_status(got);
	check_word("status right after reset", got, '0);
	exp_alive = '1;
	check_status("status with cores alive");
endtask

task automatic test_halt_resume();
	lines mask;
	lines sub;
	$display("test 2: halt and resume");
	mask = nonzero_mask();
	write_cmd(HALT, mask);
	check_lines("halt one edge after halt write", halt, exp_halt);  // not yet
	next_cycle();
	exp_halt = exp_halt | mask;
	check_lines("halt two edges after halt write", halt, exp_halt);
	check_lines("step during halt", step, '0);
	settle();
	check_status("status after halt");

	sub = mask & random_mask();
	if (sub == '0) begin
		sub = mask & (~mask + lines'(1));  // lowest halted core
	end
	write_cmd(RESUME, sub);
	check_lines("halt one edge after resume write", halt, exp_halt);
	next_cycle();
	exp_halt = exp_halt & ~sub;
	check_lines("halt after partial resume", halt, exp_halt);
	settle();
	check_status("status after partial resume");
	release_all();
endtask

task automatic test_step();
	lines hmask;
	lines smask;
	$display("test 3: single step");
	hmask = nonzero_mask() & ~lines'(1);  // core 0 stays running
	if (hmask == '0) begin
		hmask = lines'(2);
	end
	write_cmd(HALT, hmask);
	next_cycle();
	exp_halt = hmask;
	settle();

	smask = random_mask() | lines'(1);  // always asks a running core too
	write_cmd(STEP, smask);
	check_lines("step one edge after step write", step, '0);
	next_cycle();
	check_lines("step pulse", step, smask & exp_halt);
	check_lines("halt during step", halt, exp_halt);
	next_cycle();
	check_lines("step after pulse", step, '0);
	check_lines("halt after step", halt, exp_halt);
	release_all();
endtask

task automatic test_breakpoint();
	lines bp_core;
	$display("test 4: breakpoints and halt-all mode");
	bp_core = lines'(1) << random_index();
	breakpoint = bp_core;
	next_cycle();
	breakpoint = '0;
	exp_halt = exp_halt | bp_core;
	exp_bp   = exp_bp | bp_core;
	check_lines("halt one edge after breakpoint", halt, exp_halt);
	settle();
	check_status("status after breakpoint");

	write_cmd(RESUME, bp_core);
	next_cycle();
	exp_halt = exp_halt & ~bp_core;
	exp_bp   = exp_bp & ~bp_core;
	check_lines("halt after resume of bp core", halt, exp_halt);
	settle();
	check_status("status after resume of bp core");

	write_cmd(SET_MODE, lines'(1));
	next_cycle();
	exp_mode = 1'b1;
	settle();
	check_status("status with halt-all mode");

	breakpoint = bp_core;
	next_cycle();
	breakpoint = '0;
	exp_halt = '1;  // every core stops on any breakpoint
	exp_bp   = exp_bp | bp_core;
	check_lines("halt after breakpoint in halt-all mode", halt, exp_halt);
	settle();
	check_status("status after halt-all breakpoint");

	write_cmd(CLR_BP, bp_core);
	next_cycle();
	exp_bp = exp_bp & ~bp_core;
	check_lines("halt after clear of bp flag", halt, exp_halt);
	settle();
	check_status("status after clear of bp flag");

	write_cmd(SET_MODE, '0);
	next_cycle();
	exp_mode = 1'b0;
	release_all();
	check_status("status after breakpoint test");
endtask

task automatic test_illegal_op();
	lines hmask;
	$display("test 5: illegal opcode");
	hmask = nonzero_mask();
	write_cmd(HALT, hmask);
	next_cycle();
	exp_halt = hmask;
	settle();

	write_cmd(4'ha, '1);  // reserved code
	check_lines("halt one edge after illegal write", halt, exp_halt);
	next_cycle();
	check_lines("halt two edges after illegal write", halt, exp_halt);
	check_lines("step after illegal write", step, '0);
	next_cycle();
	check_lines("halt three edges after illegal write", halt, exp_halt);

	exp_err = 1'b1;
	check_status("first read after illegal opcode");
	exp_err = 1'b0;  // cleared by the read that returned it
	check_status("second read after illegal opcode");
	release_all();
endtask

/* sim/smp_ctrl_tb.sv */
`timescale 1ns/1ps

module smp_ctrl_tb;
	import bus_pkg::*;
	import smp_pkg::*;

	localparam int num_cores       = 4;
	localparam int clk_period      = 40;
	localparam int drive_delay     = 2;  // inputs change this long after the rising edge
	localparam int reset_cycles    = 4;
	localparam int num_tests       = 5;
	localparam int cycles_per_test = 200;
	localparam int watchdog_ns     = num_tests * cycles_per_test * clk_period;

	typedef logic [num_cores-1:0] lines;

	logic clk           = 1'b0;
	logic arst_n        = 1'b0;
	logic avl_read      = 1'b0;
	logic avl_write     = 1'b0;
	word  avl_writedata = '0;
	word  avl_readdata;
	lines step;
	lines halt;
	lines breakpoint    = '0;
	lines cpu_alive     = '0;
	lines cpu_halted    = '0;

	// expected DUT state from the command rules
	lines exp_alive = '0;
	lines exp_halt  = '0;
	lines exp_bp    = '0;
	logic exp_mode  = 1'b0;
	logic exp_err   = 1'b0;

	int errors = 0;
	int checks = 0;

	logic [31:0] lfsr_state = 32'h603d_aed9;

	smp_ctrl #(.NUM_CORES(num_cores)) dut0 (
		.clk           (clk),
		.arst_n        (arst_n),
		.avl_read      (avl_read),
		.avl_write     (avl_write),
		.avl_writedata (avl_writedata),
		.avl_readdata  (avl_readdata),
		.step          (step),
		.halt          (halt),
		.breakpoint    (breakpoint),
		.cpu_alive     (cpu_alive),
		.cpu_halted    (cpu_halted)
	);

	always #(clk_period / 2) clk = ~clk;

	// core model goes alive out of reset and follows halt one cycle late
	always @(posedge clk or negedge arst_n) begin : core_model
		lines halt_seen;
		if (!arst_n) begin
			cpu_alive  = '0;
			cpu_halted = '0;
		end else begin
			halt_seen = halt;  // value before this edge
			#(drive_delay);
			cpu_alive  = '1;
			cpu_halted = halt_seen;
		end
	end

	// taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	function automatic lines random_mask();
		lines m;
		for (int i = 0; i < num_cores; i++) begin
			m[i] = lfsr_bit();
		end
		return m;
	endfunction

	function automatic lines nonzero_mask();
		lines m;
		m = random_mask();
		if (m == '0) begin
			m = lines'(1);
		end
		return m;
	endfunction

	function automatic int random_index();
		int v;
		v = 0;
		for (int i = 0; i < 8; i++) begin
			v = (v << 1) | int'(lfsr_bit());
		end
		return v % num_cores;
	endfunction

	// status word as laid out for the read port
	function automatic word expected_status(input lines alive, input lines halted,
			input lines hreq, input lines bp, input logic md, input logic er);
		word w;
		w = '0;
		for (int i = 0; i < num_cores; i++) begin
			w[i]      = alive[i];
			w[8 + i]  = halted[i];
			w[16 + i] = bp[i];
			w[24 + i] = hreq[i];  // halt requests of cores 0 to 5
		end
		w[30] = md;
		w[31] = er;
		return w;
	endfunction

	task automatic check_word(input string field, input word got, input word exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %h, expected %h", $time, field, got, exp);
		end
	endtask

	task automatic check_lines(input string field, input lines got, input lines exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t ns %s: got %b, expected %b", $time, field, got, exp);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#(drive_delay);
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) next_cycle();
	endtask

	// returns just after the edge that samples the write
	task automatic write_cmd(input logic [3:0] op, input lines mask);
		word w;
		w = '0;
		w[31:28] = op;
		w[num_cores-1:0] = mask;
		avl_write     = 1'b1;
		avl_writedata = w;
		next_cycle();
		avl_write     = 1'b0;
		avl_writedata = '0;
	endtask

	task automatic read_status(output word data);
		avl_read = 1'b1;
		next_cycle();
		avl_read = 1'b0;
		data = avl_readdata;  // snapshot from before the read edge
	endtask

	task automatic check_status(input string field);
		word got;
		read_status(got);
		check_word(field, got, expected_status(exp_alive, exp_halt, exp_halt, exp_bp,
				exp_mode, exp_err));
	endtask

	task automatic settle();
		wait_cycles(3);  // halt register plus core model
	endtask

	task automatic release_all();
		write_cmd(RESUME, '1);
		next_cycle();
		exp_halt = '0;
		exp_bp   = '0;
		check_lines("halt after resume all", halt, exp_halt);
		settle();
	endtask

	`include "smp_ctrl_tests.svh"

	initial begin : main
		repeat (reset_cycles) @(posedge clk);
		#(drive_delay);
		arst_n = 1'b1;

		test_reset_state();
		test_halt_resume();
		test_step();
		test_breakpoint();
		test_illegal_op();

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("timeout: tests did not finish within %0d ns", watchdog_ns);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

/* smp_ctrl.f */
+incdir+sim
hdl/bus_pkg.sv
hdl/smp_pkg.sv
hdl/smp_cmd_if.sv
hdl/smp_cmd_decode.sv
hdl/smp_run_ctrl.sv
hdl/smp_status.sv
hdl/smp_ctrl.sv
sim/smp_ctrl_tb.sv
